// ==== common/dmaCtl_consts.svh ====
// Channel count is fixed at 4 because the register map and status byte layout depend on it
`ifndef DMA_CTL_CONSTS_SVH
`define DMA_CTL_CONSTS_SVH

// Sizes
`define DMA_NUM_CH 4
`define DMA_DATA_W 8
`define DMA_ADDR_W 16
`define DMA_PORT_W 4

// Register offsets; 0 to 7 are channel address (even) and count (odd)
`define DMA_OFS_CMD     4'd8
`define DMA_OFS_MASK1   4'd10
`define DMA_OFS_MODE    4'd11
`define DMA_OFS_CLRFF   4'd12
`define DMA_OFS_MCLR    4'd13
`define DMA_OFS_CLRMASK 4'd14
`define DMA_OFS_MASKALL 4'd15

// Mode byte bits
`define DMA_MODE_AUTOINIT 4
`define DMA_MODE_DEC      5

`endif

// ==== common/dmaRegPkg.sv ====
// Register-side formats; channel fields are 2 bits wide, so exactly four channels are supported
`include "dmaCtl_consts.svh"

package dmaRegPkg;

	// Decoded CPU access kinds
	typedef enum logic [3:0] {
		none,
		addrWr,
		cntWr,
		addrRd,
		cntRd,
		cmdWr,
		statusRd,
		mask1Wr,
		modeWr,
		clrFf,
		mclr,
		clrMask,
		maskAllWr
	} regKind_e;

	typedef struct packed {
		regKind_e                kind;
		logic [1:0]              ch;
		logic                    hiByte;
		logic [`DMA_DATA_W-1:0] data;
	} regAccess_t;

	typedef struct packed {
		logic autoinit;
		logic dec;
	} chanMode_t;

	typedef chanMode_t [`DMA_NUM_CH-1:0] chanModeArr_t;

	// Same data byte, decoded as a mode write or as a single mask write
	typedef union packed {
		struct packed {
			logic [1:0] rsvdHi;
			logic       dec;
			logic       autoinit;
			logic [1:0] rsvdLo;
			logic [1:0] ch;
		} mode;
		struct packed {
			logic [4:0] rsvd;
			logic       setMask;
			logic [1:0] ch;
		} mask1;
	} ctlByte_u;

endpackage

// ==== common/dmaBusPkg.sv ====
// Bus-side structs; the CPU port has no handshake, one access per cycle while sel is high
`include "dmaCtl_consts.svh"

package dmaBusPkg;

	// CPU request, sampled on every rising clock edge
	typedef struct packed {
		logic                    sel;
		logic                    wr;
		logic [`DMA_PORT_W-1:0] addr;
		logic [`DMA_DATA_W-1:0] wrData;
	} cpuBus_t;

	// Completed transfer, valid for the cycle in which dack drops
	typedef struct packed {
		logic       valid;
		logic [1:0] ch;
	} stepCmd_t;

	// Last transfer of a channel
	typedef struct packed {
		logic       valid;
		logic [1:0] ch;
		logic       reloaded;
	} tcEvent_t;

endpackage

// ==== regs/cpuRegPort.sv ====
// Writes act at the access edge; read data lands one cycle later and rdData is undefined before the first read
`timescale 1ns/1ps
`include "dmaCtl_consts.svh"

module cpuRegPort (
	input  logic                    dif,
	input  logic                    arstN,
	input  dmaBusPkg::cpuBus_t      cpu,
	input  logic [`DMA_DATA_W-1:0]  chanRdByte,
	input  logic [`DMA_DATA_W-1:0]  ctlRdByte,
	output dmaRegPkg::regAccess_t   access,
	output logic [`DMA_DATA_W-1:0]  rdData,
	output logic                    rdValid
);

	logic bytePtr;
	logic isWordAcc;
	logic isRead;

	// Offset and direction decode
	always_comb
	begin
		access.kind   = dmaRegPkg::none;
		access.ch     = cpu.addr[2:1];
		access.hiByte = bytePtr;
		access.data   = cpu.wrData;
		if (cpu.sel)
		begin
			if (!cpu.addr[3])
			begin
				// Odd offsets are the count registers
				if (cpu.addr[0])
					access.kind = cpu.wr ? dmaRegPkg::cntWr : dmaRegPkg::cntRd;
				else
					access.kind = cpu.wr ? dmaRegPkg::addrWr : dmaRegPkg::addrRd;
			end
			else if (cpu.addr == `DMA_OFS_CMD)
				access.kind = cpu.wr ? dmaRegPkg::cmdWr : dmaRegPkg::statusRd;
			else if (cpu.wr)
			begin
				case (cpu.addr)
					`DMA_OFS_MASK1:   access.kind = dmaRegPkg::mask1Wr;
					`DMA_OFS_MODE:    access.kind = dmaRegPkg::modeWr;
					`DMA_OFS_CLRFF:   access.kind = dmaRegPkg::clrFf;
					`DMA_OFS_MCLR:    access.kind = dmaRegPkg::mclr;
					`DMA_OFS_CLRMASK: access.kind = dmaRegPkg::clrMask;
					`DMA_OFS_MASKALL: access.kind = dmaRegPkg::maskAllWr;
					default:          access.kind = dmaRegPkg::none;
				endcase
			end
		end
	end

	assign isWordAcc = (access.kind == dmaRegPkg::addrWr) || (access.kind == dmaRegPkg::cntWr) ||
		(access.kind == dmaRegPkg::addrRd) || (access.kind == dmaRegPkg::cntRd);
	assign isRead = (access.kind == dmaRegPkg::addrRd) || (access.kind == dmaRegPkg::cntRd) ||
		(access.kind == dmaRegPkg::statusRd);

	// Byte pointer, low byte first
	always_ff @(posedge dif or negedge arstN)
	begin
		if (!arstN)
			bytePtr <= 1'b0;
		else if (access.kind == dmaRegPkg::mclr || access.kind == dmaRegPkg::clrFf)
			bytePtr <= 1'b0;
		else if (isWordAcc)
			bytePtr <= ~bytePtr;
	end

	always_ff @(posedge dif or negedge arstN)
	begin
		if (!arstN)
			rdValid <= 1'b0;
		else
			rdValid <= isRead;
	end

	// Captured before the status read clears TC
	always_ff @(posedge dif)
	begin
		if (isRead)
			rdData <= (access.kind == dmaRegPkg::statusRd) ? ctlRdByte : chanRdByte;
	end

endmodule

// ==== regs/ctlRegs.sv ====
// Master clear leaves all channels unmasked; command byte bit 2 is the only command bit kept (disable)
`timescale 1ns/1ps
`include "dmaCtl_consts.svh"

module ctlRegs (
	input  logic                    dif,
	input  logic                    arstN,
	input  dmaRegPkg::regAccess_t   access,
	input  dmaBusPkg::tcEvent_t     tcEvent,
	input  logic [`DMA_NUM_CH-1:0]  dreq,
	output dmaRegPkg::chanModeArr_t modes,
	output logic [`DMA_NUM_CH-1:0]  mask,
	output logic                    enable,
	output logic [`DMA_DATA_W-1:0]  ctlRdByte
);

	dmaRegPkg::ctlByte_u     ctl;
	logic                    ctlDisable;
	logic [`DMA_NUM_CH-1:0]  tc;

	assign ctl = access.data;

	always_ff @(posedge dif or negedge arstN)
	begin
		if (!arstN)
		begin
			modes      <= '0;
			mask       <= '0;
			ctlDisable <= 1'b0;
			tc         <= '0;
		end
		else if (access.kind == dmaRegPkg::mclr)
		begin
			modes      <= '0;
			mask       <= '0;
			ctlDisable <= 1'b0;
			tc         <= '0;
		end
		else
		begin
			case (access.kind)
				dmaRegPkg::modeWr:
				begin
					modes[ctl.mode.ch].autoinit <= ctl.mode.autoinit;
					modes[ctl.mode.ch].dec      <= ctl.mode.dec;
				end
				dmaRegPkg::mask1Wr:   mask[ctl.mask1.ch] <= ctl.mask1.setMask;
				dmaRegPkg::maskAllWr: mask <= access.data[`DMA_NUM_CH-1:0];
				dmaRegPkg::clrMask:   mask <= '0;
				// Controller disable
				dmaRegPkg::cmdWr:     ctlDisable <= access.data[2];
				// Clear on read
				dmaRegPkg::statusRd:  tc <= '0;
				default:              ;
			endcase
			// A TC in the same cycle wins over the CPU access
			if (tcEvent.valid)
			begin
				tc[tcEvent.ch] <= 1'b1;
				if (!tcEvent.reloaded)
					mask[tcEvent.ch] <= 1'b1;
			end
		end
	end

	assign enable    = ~ctlDisable;
	assign ctlRdByte = {dreq, tc};

endmodule

// ==== channel/chanFile.sv ====
// A CPU write wins over a step to the same channel in the same cycle; a non-autoinit count wraps to FFFF
`timescale 1ns/1ps
`include "dmaCtl_consts.svh"

module chanFile (
	input  logic                    dif,
	input  logic                    arstN,
	input  dmaRegPkg::regAccess_t   access,
	input  dmaBusPkg::stepCmd_t     step,
	input  dmaRegPkg::chanModeArr_t modes,
	input  logic [1:0]              grantCh,
	output logic [`DMA_ADDR_W-1:0]  grantAddr,
	output logic [`DMA_DATA_W-1:0]  chanRdByte,
	output dmaBusPkg::tcEvent_t     tcEvent
);

	logic [`DMA_ADDR_W-1:0] baseAddr [`DMA_NUM_CH];
	logic [`DMA_ADDR_W-1:0] curAddr  [`DMA_NUM_CH];
	logic [`DMA_ADDR_W-1:0] baseCnt  [`DMA_NUM_CH];
	logic [`DMA_ADDR_W-1:0] curCnt   [`DMA_NUM_CH];
	logic [`DMA_ADDR_W-1:0] rdWord;
	dmaRegPkg::chanMode_t   stepMode;
	logic                   lastXfer;

	// Replace one byte of a word
	function automatic logic [`DMA_ADDR_W-1:0] putByte(input logic [`DMA_ADDR_W-1:0] word,
		input logic [`DMA_DATA_W-1:0] data, input logic hi);
		logic [`DMA_ADDR_W-1:0] res;
		res = word;
		if (hi)
			res[`DMA_ADDR_W-1:`DMA_DATA_W] = data;
		else
			res[`DMA_DATA_W-1:0] = data;
		return res;
	endfunction

	assign stepMode = modes[step.ch];
	// Count of 0 before the step means this is the last transfer
	assign lastXfer = (curCnt[step.ch] == '0);

	assign tcEvent.valid    = step.valid && lastXfer;
	assign tcEvent.ch       = step.ch;
	assign tcEvent.reloaded = stepMode.autoinit;

	always_ff @(posedge dif or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < `DMA_NUM_CH; i++)
			begin
				baseAddr[i] <= '0;
				curAddr[i]  <= '0;
				baseCnt[i]  <= '0;
				curCnt[i]   <= '0;
			end
		end
		else if (access.kind == dmaRegPkg::mclr)
		begin
			for (int i = 0; i < `DMA_NUM_CH; i++)
			begin
				baseAddr[i] <= '0;
				curAddr[i]  <= '0;
				baseCnt[i]  <= '0;
				curCnt[i]   <= '0;
			end
		end
		else
		begin
			if (step.valid)
			begin
				if (lastXfer && stepMode.autoinit)
				begin
					curAddr[step.ch] <= baseAddr[step.ch];
					curCnt[step.ch]  <= baseCnt[step.ch];
				end
				else
				begin
					curAddr[step.ch] <= stepMode.dec ? curAddr[step.ch] - `DMA_ADDR_W'(1)
						: curAddr[step.ch] + `DMA_ADDR_W'(1);
					curCnt[step.ch]  <= curCnt[step.ch] - `DMA_ADDR_W'(1);
				end
			end
			// Program writes load base and current together
			if (access.kind == dmaRegPkg::addrWr)
			begin
				baseAddr[access.ch] <= putByte(baseAddr[access.ch], access.data, access.hiByte);
				curAddr[access.ch]  <= putByte(curAddr[access.ch], access.data, access.hiByte);
			end
			else if (access.kind == dmaRegPkg::cntWr)
			begin
				baseCnt[access.ch] <= putByte(baseCnt[access.ch], access.data, access.hiByte);
				curCnt[access.ch]  <= putByte(curCnt[access.ch], access.data, access.hiByte);
			end
		end
	end

	assign grantAddr = curAddr[grantCh];

	// Readback of current registers only
	assign rdWord     = (access.kind == dmaRegPkg::cntRd) ? curCnt[access.ch] : curAddr[access.ch];
	assign chanRdByte = access.hiByte ? rdWord[`DMA_ADDR_W-1:`DMA_DATA_W] : rdWord[`DMA_DATA_W-1:0];

endmodule

// ==== channel/xferEngine.sv ====
// Fixed priority with channel 0 highest; mask and enable are sampled only when a grant is made
`timescale 1ns/1ps
`include "dmaCtl_consts.svh"

module xferEngine (
	input  logic                    dif,
	input  logic                    arstN,
	input  logic [`DMA_NUM_CH-1:0]  dreq,
	input  logic [`DMA_NUM_CH-1:0]  mask,
	input  logic                    enable,
	input  logic [`DMA_ADDR_W-1:0]  grantAddr,
	output logic [`DMA_NUM_CH-1:0]  dack,
	output logic [`DMA_ADDR_W-1:0]  dmaAddr,
	output logic [1:0]              grantCh,
	output dmaBusPkg::stepCmd_t     step
);

	typedef enum logic {
		idle,
		acked
	} state_e;

	state_e                  state;
	logic [1:0]              heldCh;
	logic [1:0]              pickCh;
	logic [`DMA_NUM_CH-1:0]  grantable;

	assign grantable = dreq & ~mask & {`DMA_NUM_CH{enable}};

	// Lowest requesting channel wins
	always_comb
	begin
		pickCh = '0;
		for (int i = `DMA_NUM_CH - 1; i >= 0; i--)
		begin
			if (grantable[i])
				pickCh = 2'(i);
		end
	end

	// While idle the address lookup follows the candidate, so it is ready at the grant edge
	assign grantCh = (state == idle) ? pickCh : heldCh;

	// Device has released its request
	assign step.valid = (state == acked) && !dreq[heldCh];
	assign step.ch    = heldCh;

	always_ff @(posedge dif or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= idle;
			heldCh  <= '0;
			dack    <= '0;
			dmaAddr <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (|grantable)
					begin
						state   <= acked;
						heldCh  <= pickCh;
						dack    <= `DMA_NUM_CH'(1) << pickCh;
						dmaAddr <= grantAddr;
					end
				end
				acked:
				begin
					if (step.valid)
					begin
						state <= idle;
						dack  <= '0;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

// ==== rtl/dmaTop.sv ====
// Separate CPU in/out data instead of a tristate bus; no memory-to-memory or software requests
`timescale 1ns/1ps
`include "dmaCtl_consts.svh"

module dmaTop (
	input  logic                    dif,
	input  logic                    arstN,
	input  dmaBusPkg::cpuBus_t      cpu,
	input  logic [`DMA_NUM_CH-1:0]  dreq,
	output logic [`DMA_DATA_W-1:0]  rdData,
	output logic                    rdValid,
	output logic [`DMA_NUM_CH-1:0]  dack,
	output logic [`DMA_ADDR_W-1:0]  dmaAddr
);

	dmaRegPkg::regAccess_t   access;
	dmaRegPkg::chanModeArr_t modes;
	dmaBusPkg::stepCmd_t     step;
	dmaBusPkg::tcEvent_t     tcEvent;
	logic [`DMA_DATA_W-1:0]  chanRdByte;
	logic [`DMA_DATA_W-1:0]  ctlRdByte;
	logic [`DMA_NUM_CH-1:0]  mask;
	logic                    enable;
	logic [1:0]              grantCh;
	logic [`DMA_ADDR_W-1:0]  grantAddr;

	cpuRegPort u_cpuRegPort (
		.dif        (dif),
		.arstN      (arstN),
		.cpu        (cpu),
		.chanRdByte (chanRdByte),
		.ctlRdByte  (ctlRdByte),
		.access     (access),
		.rdData     (rdData),
		.rdValid    (rdValid)
	);

	ctlRegs u_ctlRegs (
		.dif       (dif),
		.arstN     (arstN),
		.access    (access),
		.tcEvent   (tcEvent),
		.dreq      (dreq),
		.modes     (modes),
		.mask      (mask),
		.enable    (enable),
		.ctlRdByte (ctlRdByte)
	);

	chanFile u_chanFile (
		.dif        (dif),
		.arstN      (arstN),
		.access     (access),
		.step       (step),
		.modes      (modes),
		.grantCh    (grantCh),
		.grantAddr  (grantAddr),
		.chanRdByte (chanRdByte),
		.tcEvent    (tcEvent)
	);

	xferEngine u_xferEngine (
		.dif       (dif),
		.arstN     (arstN),
		.dreq      (dreq),
		.mask      (mask),
		.enable    (enable),
		.grantAddr (grantAddr),
		.dack      (dack),
		.dmaAddr   (dmaAddr),
		.grantCh   (grantCh),
		.step      (step)
	);

endmodule

// ==== tests/dmaTb.sv ====
// Status reads expect the driven dreq pattern; only one CPU access or handshake is in flight at once
`timescale 1ns/1ps
`include "dmaCtl_consts.svh"

module dmaTb;

	typedef struct packed {
		logic [`DMA_ADDR_W-1:0] addr;
		logic [`DMA_ADDR_W-1:0] cnt;
		logic                   tc;
	} stepRes_t;

	// About 110 one-cycle accesses and 20 short handshakes, with a wide margin
	localparam int cycleLimit = 4000;

	logic                    dif;
	logic                    arstN;
	dmaBusPkg::cpuBus_t      cpu;
	logic [`DMA_NUM_CH-1:0]  dreq;
	logic [`DMA_DATA_W-1:0]  rdData;
	logic                    rdValid;
	logic [`DMA_NUM_CH-1:0]  dack;
	logic [`DMA_ADDR_W-1:0]  dmaAddr;

	// Reference register state
	logic [`DMA_ADDR_W-1:0]  mBaseA [`DMA_NUM_CH];
	logic [`DMA_ADDR_W-1:0]  mCurA  [`DMA_NUM_CH];
	logic [`DMA_ADDR_W-1:0]  mBaseC [`DMA_NUM_CH];
	logic [`DMA_ADDR_W-1:0]  mCurC  [`DMA_NUM_CH];
	logic [`DMA_NUM_CH-1:0]  mAuto;
	logic [`DMA_NUM_CH-1:0]  mDec;
	logic [`DMA_NUM_CH-1:0]  mMask;
	logic [`DMA_NUM_CH-1:0]  mTc;
	logic                    mDis;
	logic                    mPtr;

	logic [`DMA_DATA_W-1:0]  expQ [$];
	int                      errors;
	int                      checks;
	int                      cycles;

	dmaTop u_dut (
		.dif     (dif),
		.arstN   (arstN),
		.cpu     (cpu),
		.dreq    (dreq),
		.rdData  (rdData),
		.rdValid (rdValid),
		.dack    (dack),
		.dmaAddr (dmaAddr)
	);

	always #50 dif = ~dif;

	// Lowest unmasked requester, nothing while disabled
	function automatic logic [`DMA_NUM_CH-1:0] refGrant(input logic [`DMA_NUM_CH-1:0] req,
		input logic [`DMA_NUM_CH-1:0] msk, input logic en);
		logic [`DMA_NUM_CH-1:0] g;
		g = '0;
		for (int i = 0; i < `DMA_NUM_CH; i++)
		begin
			if (en && req[i] && !msk[i] && g == '0)
				g[i] = 1'b1;
		end
		return g;
	endfunction

	// One transfer on a channel; count 0 before the step is the last one
	function automatic stepRes_t refStep(input logic [`DMA_ADDR_W-1:0] curA,
		input logic [`DMA_ADDR_W-1:0] curC, input logic [`DMA_ADDR_W-1:0] baseA,
		input logic [`DMA_ADDR_W-1:0] baseC, input logic autoinit, input logic dec);
		stepRes_t r;
		r.tc = (curC == '0);
		if (r.tc && autoinit)
		begin
			r.addr = baseA;
			r.cnt  = baseC;
		end
		else
		begin
			r.addr = dec ? curA - 16'd1 : curA + 16'd1;
			r.cnt  = curC - 16'd1;
		end
		return r;
	endfunction

	function automatic logic [`DMA_ADDR_W-1:0] withByte(input logic [`DMA_ADDR_W-1:0] w,
		input logic [`DMA_DATA_W-1:0] b, input logic hi);
		return hi ? {b, w[7:0]} : {w[15:8], b};
	endfunction

	function void clearModel();
		for (int i = 0; i < `DMA_NUM_CH; i++)
		begin
			mBaseA[i] = '0;
			mCurA[i]  = '0;
			mBaseC[i] = '0;
			mCurC[i]  = '0;
		end
		mAuto = '0;
		mDec  = '0;
		mMask = '0;
		mTc   = '0;
		mDis  = 1'b0;
		mPtr  = 1'b0;
	endfunction

	task automatic checkByte(input string name, input logic [`DMA_DATA_W-1:0] got,
		input logic [`DMA_DATA_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Address only matters while a channel is acknowledged
	task automatic checkAck(input logic [`DMA_NUM_CH-1:0] expAck,
		input logic [`DMA_ADDR_W-1:0] expAddr);
		checks++;
		if (dack !== expAck)
		begin
			$display("ERROR %0t dack: got %b expected %b", $time, dack, expAck);
			errors++;
		end
		else if (expAck != '0 && dmaAddr !== expAddr)
		begin
			$display("ERROR %0t dmaAddr: got %h expected %h", $time, dmaAddr, expAddr);
			errors++;
		end
	endtask

	// Called and returns 1 ns after a rising edge
	task automatic driveAccess(input logic wr, input logic [`DMA_PORT_W-1:0] ofs,
		input logic [`DMA_DATA_W-1:0] data);
		cpu.sel    = 1'b1;
		cpu.wr     = wr;
		cpu.addr   = ofs;
		cpu.wrData = data;
		@(posedge dif);
		#1;
		cpu = '0;
	endtask

	task automatic wrByte(input logic [`DMA_PORT_W-1:0] ofs, input logic [`DMA_DATA_W-1:0] data);
		int ch;
		ch = int'(ofs[2:1]);
		if (!ofs[3])
		begin
			if (ofs[0])
			begin
				mBaseC[ch] = withByte(mBaseC[ch], data, mPtr);
				mCurC[ch]  = withByte(mCurC[ch], data, mPtr);
			end
			else
			begin
				mBaseA[ch] = withByte(mBaseA[ch], data, mPtr);
				mCurA[ch]  = withByte(mCurA[ch], data, mPtr);
			end
			mPtr = ~mPtr;
		end
		else
		begin
			case (ofs)
				`DMA_OFS_CMD:     mDis = data[2];
				`DMA_OFS_MASK1:   mMask[data[1:0]] = data[2];
				`DMA_OFS_MODE:
				begin
					mAuto[data[1:0]] = data[`DMA_MODE_AUTOINIT];
					mDec[data[1:0]]  = data[`DMA_MODE_DEC];
				end
				`DMA_OFS_CLRFF:   mPtr = 1'b0;
				`DMA_OFS_MCLR:    clearModel();
				`DMA_OFS_CLRMASK: mMask = '0;
				`DMA_OFS_MASKALL: mMask = data[`DMA_NUM_CH-1:0];
				default:          ;
			endcase
		end
		driveAccess(1'b1, ofs, data);
	endtask

	task automatic rdByte(input logic [`DMA_PORT_W-1:0] ofs);
		logic [`DMA_ADDR_W-1:0] w;
		int                     ch;
		ch = int'(ofs[2:1]);
		if (ofs == `DMA_OFS_CMD)
		begin
			expQ.push_back({dreq, mTc});
			mTc = '0;
		end
		else
		begin
			w = ofs[0] ? mCurC[ch] : mCurA[ch];
			expQ.push_back(mPtr ? w[15:8] : w[7:0]);
			mPtr = ~mPtr;
		end
		driveAccess(1'b0, ofs, '0);
	endtask

	task automatic wrWord(input logic [`DMA_PORT_W-1:0] ofs, input logic [`DMA_ADDR_W-1:0] w);
		wrByte(ofs, w[7:0]);
		wrByte(ofs, w[15:8]);
	endtask

	task automatic rdWord(input logic [`DMA_PORT_W-1:0] ofs);
		rdByte(ofs);
		rdByte(ofs);
	endtask

	// Full four-phase handshake, or a watch for no acknowledge
	task automatic xfer(input logic [`DMA_NUM_CH-1:0] req);
		logic [`DMA_NUM_CH-1:0] expAck;
		stepRes_t               res;
		int                     ch;
		expAck = refGrant(req, mMask, !mDis);
		ch = 0;
		for (int i = 0; i < `DMA_NUM_CH; i++)
		begin
			if (expAck[i])
				ch = i;
		end
		dreq = req;
		if (expAck == '0)
		begin
			repeat (4)
			begin
				@(negedge dif);
				checkAck(expAck, '0);
			end
			@(posedge dif);
			#1;
			dreq = '0;
		end
		else
		begin
			do @(negedge dif); while (dack == '0);
			checkAck(expAck, mCurA[ch]);
			@(posedge dif);
			#1;
			dreq = '0;
			do @(negedge dif); while (dack != '0);
			res = refStep(mCurA[ch], mCurC[ch], mBaseA[ch], mBaseC[ch], mAuto[ch], mDec[ch]);
			mCurA[ch] = res.addr;
			mCurC[ch] = res.cnt;
			if (res.tc)
			begin
				mTc[ch] = 1'b1;
				if (!mAuto[ch])
					mMask[ch] = 1'b1;
			end
			@(posedge dif);
			#1;
		end
	endtask

	// Read data compare, sampled mid-cycle
	always @(negedge dif)
	begin
		if (arstN && rdValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("Read data appeared at %0t with no read pending", $time);
				errors++;
			end
			else
				checkByte("rdData", rdData, expQ.pop_front());
		end
	end

	always @(posedge dif)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'he4bc_2cd7));
		dif    = 1'b0;
		arstN  = 1'b0;
		cpu    = '0;
		dreq   = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		clearModel();
		repeat (5) @(posedge dif);
		#1;
		arstN = 1'b1;

		// Register readback, then again after clear-FF
		for (int i = 0; i < 2 * `DMA_NUM_CH; i++)
			wrWord(4'(i), 16'($urandom));
		for (int i = 0; i < 2 * `DMA_NUM_CH; i++)
			rdWord(4'(i));
		wrByte(4'd0, 8'($urandom));
		wrByte(`DMA_OFS_CLRFF, 8'h00);
		for (int i = 0; i < 2 * `DMA_NUM_CH; i++)
			rdWord(4'(i));

		// Single transfers, ch0 increment and ch1 decrement
		wrByte(`DMA_OFS_MODE, 8'h00);
		wrByte(`DMA_OFS_MODE, 8'h21);
		xfer(4'b0001);
		xfer(4'b0010);
		for (int i = 0; i < 4; i++)
			rdWord(4'(i));

		// Priority, masking and disable
		xfer(4'b1111);
		wrByte(`DMA_OFS_MASK1, 8'h04);
		xfer(4'b1111);
		wrByte(`DMA_OFS_MASKALL, 8'h07);
		xfer(4'b1111);
		wrByte(`DMA_OFS_MASKALL, 8'h0f);
		xfer(4'b1111);
		wrByte(`DMA_OFS_CLRMASK, 8'h00);
		wrByte(`DMA_OFS_CMD, 8'h04);
		xfer(4'b1111);
		wrByte(`DMA_OFS_CMD, 8'h00);
		xfer(4'b0110);

		// Terminal count without and with autoinit
		wrByte(`DMA_OFS_MODE, 8'h02);
		wrWord(4'd5, 16'h0000);
		xfer(4'b0100);
		rdByte(`DMA_OFS_CMD);
		rdByte(`DMA_OFS_CMD);
		xfer(4'b0100);
		wrByte(`DMA_OFS_MODE, 8'h13);
		wrWord(4'd6, 16'($urandom));
		wrWord(4'd7, 16'h0001);
		xfer(4'b1000);
		xfer(4'b1000);
		rdWord(4'd6);
		rdWord(4'd7);
		rdByte(`DMA_OFS_CMD);

		// Clear mask, then master clear
		wrByte(`DMA_OFS_MASKALL, 8'h0f);
		xfer(4'b1000);
		// Status shows pending requests even while masked
		dreq = 4'b1010;
		rdByte(`DMA_OFS_CMD);
		dreq = '0;
		wrByte(`DMA_OFS_CLRMASK, 8'h00);
		xfer(4'b1000);
		wrWord(4'd1, 16'h0000);
		xfer(4'b0001);
		wrByte(`DMA_OFS_MCLR, 8'h00);
		for (int i = 0; i < 2 * `DMA_NUM_CH; i++)
			rdWord(4'(i));
		rdByte(`DMA_OFS_CMD);
		xfer(4'b0001);

		repeat (2) @(posedge dif);
		if (expQ.size() != 0)
		begin
			$display("Read data never arrived for %0d pending reads", expQ.size());
			errors++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+common
common/dmaRegPkg.sv
common/dmaBusPkg.sv
regs/cpuRegPort.sv
regs/ctlRegs.sv
channel/chanFile.sv
channel/xferEngine.sv
rtl/dmaTop.sv
tests/dmaTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dmaTb -f sources.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "TB PASSED" sim.log; then
	exit 0
fi
exit 1
